// ==== dual_issue_stage.f ====
logic/isa_pkg.sv
logic/issue_pkg.sv
logic/issue_slot_if.sv
logic/inst_decoder.sv
logic/dual_dispatcher.sv
logic/issue_latch.sv
logic/dual_issue_stage.sv
verification/dual_issue_stage_tb.sv

// ==== verification/dual_issue_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dual_issue_stage_tb;
    import isa_pkg::*;
    import issue_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int N_DIRECTED   = 40;
    localparam int N_RANDOM     = 200;
    // drain and margin on top of the pair count
    localparam int SLACK        = 150;
    localparam int MAX_CYCLES   = RESET_CYCLES + N_DIRECTED + N_RANDOM + SLACK;

    // one execute-entry register as seen on the top-level ports
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   ir;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rj;
        logic [REG_W-1:0]  rk;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   control;
        logic [EXCP_W-1:0] excp_arg;
        logic [PRED_W-1:0] pre;
    } ex_t;

    logic clk, rstn, flush, stall;
    logic valid0, valid1;
    logic [XLEN-1:0] pc0, pc1, ir0, ir1;
    logic [EXCP_W-1:0] excp_arg0, excp_arg1;
    logic [PRED_W-1:0] pre0, pre1;
    logic issue0, issue1;
    logic ex0_valid, ex1_valid;
    logic [XLEN-1:0] ex0_pc, ex0_ir, ex0_imm, ex0_control;
    logic [XLEN-1:0] ex1_pc, ex1_ir, ex1_imm, ex1_control;
    logic [REG_W-1:0] ex0_rd, ex0_rj, ex0_rk, ex1_rd, ex1_rj, ex1_rk;
    logic [EXCP_W-1:0] ex0_excp_arg, ex1_excp_arg;
    logic [PRED_W-1:0] ex0_pre, ex1_pre;

    // reference model state
    logic [4:0]       c0, c1;
    logic             dep, blk0, blk1, exp_i0, exp_i1;
    logic [REG_W-1:0] m_rd0, m_rd1;
    logic             m_two0, m_two1;
    ex_t              exp_ex0, exp_ex1, act_ex0, act_ex1;
    logic [31:0]      lfsr = 32'hf17d_27c6;
    logic [31:0]      next_pc = 32'h1c00_0000;
    int               cycles = 0;

    dual_issue_stage dut_i (.*);

    assign act_ex0 = {ex0_valid, ex0_pc, ex0_ir, ex0_rd, ex0_rj, ex0_rk, ex0_imm,
                      ex0_control, ex0_excp_arg, ex0_pre};
    assign act_ex1 = {ex1_valid, ex1_pc, ex1_ir, ex1_rd, ex1_rj, ex1_rk, ex1_imm,
                      ex1_control, ex1_excp_arg, ex1_pre};

    always #50 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    // {regwrite, exec type} from the opcode table
    function automatic logic [4:0] ref_class(input logic [31:0] ir);
        case (ir[31:26])
            op_add:             return {1'b1, ex_alu};
            op_beq:             return {1'b0, ex_br};
            op_div:             return {1'b1, ex_div};
            op_csrrd, op_csrwr: return {1'b1, ex_priv};
            op_mul:             return {1'b1, ex_mul};
            op_ld:              return {1'b1, ex_dcache};
            op_st:              return {1'b0, ex_dcache};
            op_csr_ld:          return {1'b1, ex_priv_dcache};
            op_rdcnt:           return {1'b1, ex_rdcnt};
            op_jal:             return {1'b1, ex_alu_br};
            op_ibar:            return {1'b0, ex_ibar};
            op_tlbsrch:         return {1'b0, ex_priv_mmu};
            op_tlbfill:         return {1'b0, ex_mmu};
            default:            return {1'b0, ex_alu};
        endcase
    endfunction

    // source operands, plus rd for a branch
    function automatic logic reads(input logic [4:0] r, input logic [31:0] ir,
                                   input logic [3:0] t);
        return (r == ir[9:5]) || (r == ir[14:10]) || ((t == ex_br) && (r == ir[4:0]));
    endfunction

    function automatic logic slow_result(input logic [4:0] c);
        return (c[3:0] inside {ex_mul, ex_dcache, ex_div}) || ((c[3:0] == ex_priv) && c[4]);
    endfunction

    function automatic logic upper_ok(input logic [3:0] t);
        return t inside {ex_alu, ex_br, ex_alu_br, ex_div, ex_mul, ex_rdcnt, ex_ibar};
    endfunction

    function automatic ex_t expect_slot(input logic v, input logic [31:0] pc,
                                        input logic [31:0] ir, input logic [15:0] ea,
                                        input logic [63:0] pr);
        ex_t        s;
        logic [4:0] c;
        c          = ref_class(ir);
        s.valid    = v;
        s.pc       = pc;
        s.ir       = ir;
        s.rd       = ir[4:0];
        s.rj       = ir[9:5];
        s.rk       = ir[14:10];
        s.imm      = {{16{ir[25]}}, ir[25:10]};
        s.control  = {25'b0, c[4], 2'b0, c[3:0]};
        s.excp_arg = ea;
        s.pre      = pr;
        return s;
    endfunction

    always_comb begin
        c1     = ref_class(ir1);
        c0     = ref_class(ir0);
        dep    = c1[4] && (ir1[4:0] != 5'd0) && reads(ir1[4:0], ir0, c0[3:0]);
        blk1   = (m_two0 && reads(m_rd0, ir1, c1[3:0])) || (m_two1 && reads(m_rd1, ir1, c1[3:0]));
        blk0   = (m_two0 && reads(m_rd0, ir0, c0[3:0])) || (m_two1 && reads(m_rd1, ir0, c0[3:0]));
        exp_i1 = !blk1;
        exp_i0 = !blk1 && !dep && upper_ok(c0[3:0]) && !blk0;
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn || flush) begin
            m_rd0   <= '0;
            m_rd1   <= '0;
            m_two0  <= 1'b0;
            m_two1  <= 1'b0;
            exp_ex0 <= '0;
            exp_ex1 <= '0;
        end else if (!stall) begin
            m_rd0   <= ir0[4:0];
            m_rd1   <= ir1[4:0];
            m_two0  <= exp_i0 && slow_result(c0);
            m_two1  <= exp_i1 && slow_result(c1);
            exp_ex0 <= exp_i0 ? expect_slot(valid0, pc0, ir0, excp_arg0, pre0) : '0;
            exp_ex1 <= exp_i1 ? expect_slot(valid1, pc1, ir1, excp_arg1, pre1) : '0;
        end
    end

    a_issue: assert property (@(posedge clk) disable iff (!rstn)
        (issue0 == exp_i0) && (issue1 == exp_i1))
        else fail_run($sformatf("ERROR at %0t: issue1/issue0 = %b%b, expected %b%b", $time,
            $sampled(issue1), $sampled(issue0), $sampled(exp_i1), $sampled(exp_i0)));

    a_pipe0: assert property (@(posedge clk) disable iff (!rstn) act_ex0 == exp_ex0)
        else fail_run($sformatf("ERROR at %0t: pipe 0 holds %h, expected %h", $time,
            $sampled(act_ex0), $sampled(exp_ex0)));

    a_pipe1: assert property (@(posedge clk) disable iff (!rstn) act_ex1 == exp_ex1)
        else fail_run($sformatf("ERROR at %0t: pipe 1 holds %h, expected %h", $time,
            $sampled(act_ex1), $sampled(exp_ex1)));

    a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        (stall && !flush) |=> ($stable(act_ex0) && $stable(act_ex1)))
        else fail_run($sformatf("ERROR at %0t: execute registers moved during stall", $time));

    a_flush_empty: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> (!ex0_valid && !ex1_valid))
        else fail_run($sformatf("ERROR at %0t: valid pipe after flush", $time));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            fail_run($sformatf("the run timed out after %0d cycles", cycles));
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // registers limited to r0..r7 so hazards come up often
    task automatic rand_ir(output logic [31:0] ir);
        logic [31:0] opc, rd, rj, rk, hi;
        rand_bits(4, opc);
        rand_bits(3, rd);
        rand_bits(3, rj);
        rand_bits(3, rk);
        rand_bits(11, hi);
        ir = {opc[5:0], hi[10:0], rk[4:0], rj[4:0], rd[4:0]};
    endtask

    function automatic logic [31:0] mk_ir(input logic [5:0] opc, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [4:0] rk,
                                          input logic [10:0] hi);
        return {opc, hi, rk, rj, rd};
    endfunction

    task automatic drive_inputs(input logic [31:0] older, input logic [31:0] younger,
                                input logic [1:0] v, input logic stall_v,
                                input logic flush_v);
        @(posedge clk);
        #5;
        ir1       = older;
        ir0       = younger;
        valid1    = v[1];
        valid0    = v[0];
        stall     = stall_v;
        flush     = flush_v;
        pc1       = next_pc;
        pc0       = next_pc + 32'd4;
        excp_arg1 = next_pc[18:3];
        excp_arg0 = ~next_pc[18:3];
        pre1      = {pc1, ~pc1};
        pre0      = {pc0 ^ 32'h5a5a_5a5a, pc0};
        next_pc   = next_pc + 32'd8;
    endtask

    task automatic issue_pair(input logic [31:0] older, input logic [31:0] younger);
        drive_inputs(older, younger, 2'b11, 1'b0, 1'b0);
    endtask

    initial begin
        logic [31:0] older, younger, b, s, f;
        clk       = 1'b0;
        rstn      = 1'b0;
        flush     = 1'b0;
        stall     = 1'b0;
        valid0    = 1'b0;
        valid1    = 1'b0;
        pc0       = '0;
        pc1       = '0;
        ir0       = '0;
        ir1       = '0;
        excp_arg0 = '0;
        excp_arg1 = '0;
        pre0      = '0;
        pre1      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rstn = 1'b1;

        // idle after reset, pipes stay empty
        drive_inputs('0, '0, 2'b00, 1'b0, 1'b0);
        drive_inputs('0, '0, 2'b00, 1'b0, 1'b0);

        // independent pairs, younger alu, mul or branch
        issue_pair(mk_ir(op_add, 1, 2, 3, 0), mk_ir(op_mul, 4, 5, 6, 0));
        issue_pair(mk_ir(op_add, 7, 8, 9, 11'h7ff), mk_ir(op_beq, 10, 11, 12, 11'h400));
        issue_pair(mk_ir(op_jal, 1, 2, 3, 0), mk_ir(op_add, 13, 14, 15, 11'h5a5));

        // single issue, dependence or lower-only younger
        issue_pair(mk_ir(op_add, 5, 1, 2, 0), mk_ir(op_add, 6, 5, 3, 0));
        issue_pair(mk_ir(op_add, 7, 1, 2, 0), mk_ir(op_beq, 7, 3, 4, 0));
        issue_pair(mk_ir(op_add, 8, 1, 2, 0), mk_ir(op_ld, 9, 3, 4, 0));
        issue_pair(mk_ir(op_add, 8, 1, 2, 0), mk_ir(op_csrrd, 9, 3, 4, 0));
        issue_pair(mk_ir(op_add, 8, 1, 2, 0), mk_ir(op_tlbfill, 9, 3, 4, 0));

        // two-cycle producers against the next pair
        issue_pair(mk_ir(op_ld, 10, 1, 2, 0), mk_ir(op_add, 11, 3, 4, 0));
        issue_pair(mk_ir(op_add, 12, 10, 3, 0), mk_ir(op_add, 13, 4, 5, 0));
        issue_pair(mk_ir(op_mul, 14, 1, 2, 0), mk_ir(op_add, 15, 3, 4, 0));
        issue_pair(mk_ir(op_add, 16, 1, 2, 0), mk_ir(op_add, 17, 14, 3, 0));
        issue_pair(mk_ir(op_ld, 0, 1, 2, 0), mk_ir(op_add, 18, 3, 4, 0));
        issue_pair(mk_ir(op_add, 19, 0, 3, 0), mk_ir(op_add, 20, 4, 5, 0));
        issue_pair(mk_ir(op_add, 21, 1, 2, 0), mk_ir(op_div, 22, 3, 4, 0));
        issue_pair(mk_ir(op_add, 23, 22, 1, 0), mk_ir(op_add, 24, 2, 3, 0));

        // stall holds the pipes and the record of mul r4
        issue_pair(mk_ir(op_add, 1, 2, 3, 0), mk_ir(op_mul, 4, 5, 6, 0));
        repeat (3) drive_inputs(mk_ir(op_add, 7, 8, 9, 0), mk_ir(op_add, 10, 11, 12, 0),
                                2'b11, 1'b1, 1'b0);
        issue_pair(mk_ir(op_add, 5, 4, 1, 0), mk_ir(op_add, 6, 2, 3, 0));

        // flush drops the mul r27 issued with it, dependent pair then issues
        issue_pair(mk_ir(op_ld, 25, 1, 2, 0), mk_ir(op_add, 26, 3, 4, 0));
        drive_inputs(mk_ir(op_mul, 27, 1, 2, 0), mk_ir(op_add, 28, 3, 4, 0),
                     2'b11, 1'b0, 1'b1);
        issue_pair(mk_ir(op_add, 1, 27, 25, 0), mk_ir(op_add, 2, 3, 4, 0));

        // flush under stall still empties the record of ld r29
        issue_pair(mk_ir(op_ld, 29, 1, 2, 0), mk_ir(op_add, 30, 3, 4, 0));
        drive_inputs(mk_ir(op_add, 5, 6, 7, 0), mk_ir(op_add, 8, 9, 10, 0),
                     2'b11, 1'b1, 1'b1);
        issue_pair(mk_ir(op_add, 1, 29, 2, 0), mk_ir(op_add, 3, 4, 5, 0));

        for (int n = 0; n < N_RANDOM; n++) begin
            rand_ir(older);
            rand_ir(younger);
            rand_bits(1, b);
            rand_bits(3, s);
            rand_bits(4, f);
            drive_inputs(older, younger, {1'b1, b[0]}, s[2:0] == 3'b111, f[3:0] == 4'hf);
        end

        drive_inputs('0, '0, 2'b00, 1'b0, 1'b0);
        repeat (2) @(posedge clk);
        #5;
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/dual_issue_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module dual_issue_stage (
    input  wire logic                        clk,
    input  wire logic                        rstn,
    input  wire logic                        flush,
    input  wire logic                        stall,
    // slot 1 is the older instruction
    input  wire logic                        valid0,
    input  wire logic [issue_pkg::XLEN-1:0]  pc0,
    input  wire logic [issue_pkg::XLEN-1:0]  ir0,
    input  wire logic [issue_pkg::EXCP_W-1:0] excp_arg0,
    input  wire logic [issue_pkg::PRED_W-1:0] pre0,
    input  wire logic                        valid1,
    input  wire logic [issue_pkg::XLEN-1:0]  pc1,
    input  wire logic [issue_pkg::XLEN-1:0]  ir1,
    input  wire logic [issue_pkg::EXCP_W-1:0] excp_arg1,
    input  wire logic [issue_pkg::PRED_W-1:0] pre1,
    // tells fetch which slots were taken
    output logic                             issue0,
    output logic                             issue1,
    output logic                             ex0_valid,
    output logic [issue_pkg::XLEN-1:0]       ex0_pc,
    output logic [issue_pkg::XLEN-1:0]       ex0_ir,
    output logic [isa_pkg::REG_W-1:0]        ex0_rd,
    output logic [isa_pkg::REG_W-1:0]        ex0_rj,
    output logic [isa_pkg::REG_W-1:0]        ex0_rk,
    output logic [issue_pkg::XLEN-1:0]       ex0_imm,
    output logic [issue_pkg::XLEN-1:0]       ex0_control,
    output logic [issue_pkg::EXCP_W-1:0]     ex0_excp_arg,
    output logic [issue_pkg::PRED_W-1:0]     ex0_pre,
    output logic                             ex1_valid,
    output logic [issue_pkg::XLEN-1:0]       ex1_pc,
    output logic [issue_pkg::XLEN-1:0]       ex1_ir,
    output logic [isa_pkg::REG_W-1:0]        ex1_rd,
    output logic [isa_pkg::REG_W-1:0]        ex1_rj,
    output logic [isa_pkg::REG_W-1:0]        ex1_rk,
    output logic [issue_pkg::XLEN-1:0]       ex1_imm,
    output logic [issue_pkg::XLEN-1:0]       ex1_control,
    output logic [issue_pkg::EXCP_W-1:0]     ex1_excp_arg,
    output logic [issue_pkg::PRED_W-1:0]     ex1_pre
);

    issue_slot_if dec0_s ();
    issue_slot_if dec1_s ();
    issue_slot_if disp0_s ();
    issue_slot_if disp1_s ();

    // fetch fields pass straight into the decoded slots
    assign dec0_s.valid    = valid0;
    assign dec0_s.pc       = pc0;
    assign dec0_s.ir       = ir0;
    assign dec0_s.excp_arg = excp_arg0;
    assign dec0_s.pre      = pre0;
    assign dec1_s.valid    = valid1;
    assign dec1_s.pc       = pc1;
    assign dec1_s.ir       = ir1;
    assign dec1_s.excp_arg = excp_arg1;
    assign dec1_s.pre      = pre1;

    inst_decoder dec0_i (.ir(ir0), .slot(dec0_s.src));
    inst_decoder dec1_i (.ir(ir1), .slot(dec1_s.src));

    dual_dispatcher disp_i (
        .clk    (clk),
        .rstn   (rstn),
        .flush  (flush),
        .stall  (stall),
        .dec0   (dec0_s.dst),
        .dec1   (dec1_s.dst),
        .disp0  (disp0_s.src),
        .disp1  (disp1_s.src),
        .issue0 (issue0),
        .issue1 (issue1)
    );

    // upper pipe
    issue_latch latch0_i (
        .clk(clk), .rstn(rstn), .flush(flush), .stall(stall),
        .issue(issue0), .disp(disp0_s.dst),
        .ex_valid(ex0_valid), .ex_pc(ex0_pc), .ex_ir(ex0_ir),
        .ex_rd(ex0_rd), .ex_rj(ex0_rj), .ex_rk(ex0_rk),
        .ex_imm(ex0_imm), .ex_control(ex0_control),
        .ex_excp_arg(ex0_excp_arg), .ex_pre(ex0_pre)
    );

    // lower, full-function pipe
    issue_latch latch1_i (
        .clk(clk), .rstn(rstn), .flush(flush), .stall(stall),
        .issue(issue1), .disp(disp1_s.dst),
        .ex_valid(ex1_valid), .ex_pc(ex1_pc), .ex_ir(ex1_ir),
        .ex_rd(ex1_rd), .ex_rj(ex1_rj), .ex_rk(ex1_rk),
        .ex_imm(ex1_imm), .ex_control(ex1_control),
        .ex_excp_arg(ex1_excp_arg), .ex_pre(ex1_pre)
    );

endmodule

`default_nettype wire

// ==== logic/issue_latch.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_latch (
    input  wire logic                      clk,
    input  wire logic                      rstn,
    input  wire logic                      flush,
    input  wire logic                      stall,
    input  wire logic                      issue,
    issue_slot_if.dst                      disp,
    output logic                           ex_valid,
    output logic [issue_pkg::XLEN-1:0]     ex_pc,
    output logic [issue_pkg::XLEN-1:0]     ex_ir,
    output logic [isa_pkg::REG_W-1:0]      ex_rd,
    output logic [isa_pkg::REG_W-1:0]      ex_rj,
    output logic [isa_pkg::REG_W-1:0]      ex_rk,
    output logic [issue_pkg::XLEN-1:0]     ex_imm,
    output logic [issue_pkg::XLEN-1:0]     ex_control,
    output logic [issue_pkg::EXCP_W-1:0]   ex_excp_arg,
    output logic [issue_pkg::PRED_W-1:0]   ex_pre
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ex_valid    <= 1'b0;
            ex_pc       <= '0;
            ex_ir       <= '0;
            ex_rd       <= '0;
            ex_rj       <= '0;
            ex_rk       <= '0;
            ex_imm      <= '0;
            ex_control  <= '0;
            ex_excp_arg <= '0;
            ex_pre      <= '0;
        end else if (flush || (!stall && !issue)) begin
            // flush, or a bubble when this pipe got nothing
            ex_valid    <= 1'b0;
            ex_pc       <= '0;
            ex_ir       <= '0;
            ex_rd       <= '0;
            ex_rj       <= '0;
            ex_rk       <= '0;
            ex_imm      <= '0;
            ex_control  <= '0;
            ex_excp_arg <= '0;
            ex_pre      <= '0;
        end else if (!stall) begin
            ex_valid    <= disp.valid;
            ex_pc       <= disp.pc;
            ex_ir       <= disp.ir;
            ex_rd       <= disp.rd;
            ex_rj       <= disp.rj;
            ex_rk       <= disp.rk;
            ex_imm      <= disp.imm;
            ex_control  <= disp.control;
            ex_excp_arg <= disp.excp_arg;
            ex_pre      <= disp.pre;
        end
    end

    // flush wins over stall and over a pending issue
    a_flush_kill: assert property (@(posedge clk) disable iff (!rstn) flush |=> !ex_valid);

endmodule

`default_nettype wire

// ==== logic/dual_dispatcher.sv ====
`timescale 1ns/10ps
`default_nettype none

module dual_dispatcher (
    input  wire logic  clk,
    input  wire logic  rstn,
    input  wire logic  flush,
    input  wire logic  stall,
    issue_slot_if.dst  dec0,
    issue_slot_if.dst  dec1,
    issue_slot_if.src  disp0,
    issue_slot_if.src  disp1,
    output logic       issue0,
    output logic       issue1
);
    import isa_pkg::*;

    exec_type_e       type0;
    exec_type_e       type1;
    logic             wr0;
    logic             wr1;
    logic             two0;
    logic             two1;
    logic             dep;
    logic             fits0;
    logic             blk0;
    logic             blk1;
    // rd and two-cycle flag of each slot issued last cycle
    logic [REG_W-1:0] rec_rd0;
    logic [REG_W-1:0] rec_rd1;
    logic             rec_two0;
    logic             rec_two1;

    // does a slot with these fields read register src
    function automatic logic reads_reg(
        input logic [REG_W-1:0] src,
        input logic [REG_W-1:0] rd,
        input logic [REG_W-1:0] rj,
        input logic [REG_W-1:0] rk,
        input exec_type_e       t
    );
        return (src == rj) || (src == rk) || ((src == rd) && (t == ex_br));
    endfunction

    // result not ready for the next issue
    function automatic logic is_two_cycle(input exec_type_e t, input logic wr);
        return (t == ex_mul) || (t == ex_dcache) || (t == ex_div) ||
               ((t == ex_priv) && wr);
    endfunction

    // upper pipe has no memory, privileged or mmu path
    function automatic logic fits_upper(input exec_type_e t);
        return t inside {ex_alu, ex_br, ex_div, ex_mul, ex_rdcnt, ex_alu_br, ex_ibar};
    endfunction

    assign type0 = exec_type_e'(dec0.control[TYPE_W-1:0]);
    assign type1 = exec_type_e'(dec1.control[TYPE_W-1:0]);
    assign wr0   = dec0.control[REGWRITE_BIT];
    assign wr1   = dec1.control[REGWRITE_BIT];
    assign two0  = is_two_cycle(type0, wr0);
    assign two1  = is_two_cycle(type1, wr1);
    assign fits0 = fits_upper(type0);

    // younger needs the older result in the same cycle
    assign dep = wr1 && (dec1.rd != '0) &&
                 reads_reg(dec1.rd, dec0.rd, dec0.rj, dec0.rk, type0);

    // record compares indices only, r0 included
    assign blk1 = (rec_two0 && reads_reg(rec_rd0, dec1.rd, dec1.rj, dec1.rk, type1)) ||
                  (rec_two1 && reads_reg(rec_rd1, dec1.rd, dec1.rj, dec1.rk, type1));
    assign blk0 = (rec_two0 && reads_reg(rec_rd0, dec0.rd, dec0.rj, dec0.rk, type0)) ||
                  (rec_two1 && reads_reg(rec_rd1, dec0.rd, dec0.rj, dec0.rk, type0));

    always_comb begin
        if (blk1) begin
            issue0 = 1'b0;
            issue1 = 1'b0;
        end else if (!dep && fits0 && !blk0) begin
            issue0 = 1'b1;
            issue1 = 1'b1;
        end else begin
            issue0 = 1'b0;
            issue1 = 1'b1;
        end
    end

    // a slot that does not issue goes out as all zeros
    assign disp0.valid    = issue0 ? dec0.valid    : '0;
    assign disp0.pc       = issue0 ? dec0.pc       : '0;
    assign disp0.ir       = issue0 ? dec0.ir       : '0;
    assign disp0.rd       = issue0 ? dec0.rd       : '0;
    assign disp0.rj       = issue0 ? dec0.rj       : '0;
    assign disp0.rk       = issue0 ? dec0.rk       : '0;
    assign disp0.imm      = issue0 ? dec0.imm      : '0;
    assign disp0.control  = issue0 ? dec0.control  : '0;
    assign disp0.excp_arg = issue0 ? dec0.excp_arg : '0;
    assign disp0.pre      = issue0 ? dec0.pre      : '0;

    assign disp1.valid    = issue1 ? dec1.valid    : '0;
    assign disp1.pc       = issue1 ? dec1.pc       : '0;
    assign disp1.ir       = issue1 ? dec1.ir       : '0;
    assign disp1.rd       = issue1 ? dec1.rd       : '0;
    assign disp1.rj       = issue1 ? dec1.rj       : '0;
    assign disp1.rk       = issue1 ? dec1.rk       : '0;
    assign disp1.imm      = issue1 ? dec1.imm      : '0;
    assign disp1.control  = issue1 ? dec1.control  : '0;
    assign disp1.excp_arg = issue1 ? dec1.excp_arg : '0;
    assign disp1.pre      = issue1 ? dec1.pre      : '0;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rec_rd0  <= '0;
            rec_rd1  <= '0;
            rec_two0 <= 1'b0;
            rec_two1 <= 1'b0;
        end else if (flush) begin
            rec_rd0  <= '0;
            rec_rd1  <= '0;
            rec_two0 <= 1'b0;
            rec_two1 <= 1'b0;
        end else if (!stall) begin
            rec_rd0  <= dec0.rd;
            rec_rd1  <= dec1.rd;
            rec_two0 <= issue0 && two0;
            rec_two1 <= issue1 && two1;
        end
    end

    // younger never issues without the older one
    a_in_order: assert property (@(posedge clk) disable iff (!rstn) issue0 |-> issue1);

    // lower-only classes never reach the upper pipe
    a_upper_only: assert property (@(posedge clk) disable iff (!rstn)
        issue0 |-> !(disp0.control[TYPE_W-1:0] inside
                     {ex_priv, ex_dcache, ex_priv_dcache, ex_priv_mmu, ex_mmu}));

endmodule

`default_nettype wire

// ==== logic/inst_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
    input  wire logic [issue_pkg::XLEN-1:0] ir,
    issue_slot_if.src                       slot
);
    import isa_pkg::*;
    import issue_pkg::*;

    opcode_e    opcode;
    exec_type_e etype;
    logic       regwrite;

    assign opcode = opcode_e'(ir[OPC_LSB +: OPC_W]);

    // register fields sit at fixed positions for every format
    assign slot.rd  = ir[RD_LSB +: REG_W];
    assign slot.rj  = ir[RJ_LSB +: REG_W];
    assign slot.rk  = ir[RK_LSB +: REG_W];
    assign slot.imm = {{(XLEN-IMM_W){ir[IMM_LSB+IMM_W-1]}}, ir[IMM_LSB +: IMM_W]};

    always_comb begin
        etype    = ex_alu;
        regwrite = 1'b1;
        case (opcode)
            op_add: begin
                etype = ex_alu;
            end
            op_beq: begin
                etype    = ex_br;
                regwrite = 1'b0;
            end
            op_div: begin
                etype = ex_div;
            end
            // csrwr hands the old csr value back in rd
            op_csrrd, op_csrwr: begin
                etype = ex_priv;
            end
            op_mul: begin
                etype = ex_mul;
            end
            op_ld: begin
                etype = ex_dcache;
            end
            op_st: begin
                etype    = ex_dcache;
                regwrite = 1'b0;
            end
            op_csr_ld: begin
                etype = ex_priv_dcache;
            end
            op_rdcnt: begin
                etype = ex_rdcnt;
            end
            // link register write
            op_jal: begin
                etype = ex_alu_br;
            end
            op_ibar: begin
                etype    = ex_ibar;
                regwrite = 1'b0;
            end
            // tlb ops touch only tlb/csr state, no gpr target
            op_tlbsrch: begin
                etype    = ex_priv_mmu;
                regwrite = 1'b0;
            end
            op_tlbfill: begin
                etype    = ex_mmu;
                regwrite = 1'b0;
            end
            default: begin
                etype    = ex_alu;
                regwrite = 1'b0;
            end
        endcase
    end

    always_comb begin
        slot.control                 = '0;
        slot.control[TYPE_W-1:0]     = etype;
        slot.control[REGWRITE_BIT]   = regwrite;
    end

endmodule

`default_nettype wire

// ==== logic/issue_slot_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one instruction slot between decode, dispatch and the execute latches
interface issue_slot_if;
    import isa_pkg::*;
    import issue_pkg::*;

    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   ir;
    logic [REG_W-1:0]  rd;
    logic [REG_W-1:0]  rj;
    logic [REG_W-1:0]  rk;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   control;
    logic [EXCP_W-1:0] excp_arg;
    logic [PRED_W-1:0] pre;

    modport src (
        output valid, pc, ir, rd, rj, rk, imm, control, excp_arg, pre
    );

    modport dst (
        input  valid, pc, ir, rd, rj, rk, imm, control, excp_arg, pre
    );

endinterface

`default_nettype wire

// ==== logic/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    // pc, ir, sign-extended immediate and control word all share this width
    localparam int XLEN = 32;

    // exception argument forwarded from fetch
    localparam int EXCP_W = 16;

    // branch prediction payload, opaque to this stage
    localparam int PRED_W = 64;

endpackage

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // register index width
    localparam int REG_W = 5;

    // instruction word layout
    localparam int OPC_LSB = 26;
    localparam int OPC_W   = 6;
    localparam int RD_LSB  = 0;
    localparam int RJ_LSB  = 5;
    localparam int RK_LSB  = 10;
    localparam int IMM_LSB = 10;
    localparam int IMM_W   = 16;

    // control word layout, type sits at the bottom
    localparam int TYPE_W       = 4;
    localparam int REGWRITE_BIT = 6;

    // major opcode in ir[31:26]
    typedef enum logic [OPC_W-1:0] {
        op_add     = 6'h00,
        op_beq     = 6'h01,
        op_div     = 6'h02,
        op_csrrd   = 6'h03,
        op_csrwr   = 6'h04,
        op_mul     = 6'h05,
        op_ld      = 6'h06,
        op_st      = 6'h07,
        op_csr_ld  = 6'h08,
        op_rdcnt   = 6'h09,
        op_jal     = 6'h0a,
        op_ibar    = 6'h0b,
        op_tlbsrch = 6'h0c,
        op_tlbfill = 6'h0d
    } opcode_e;

    // execution class carried in control[3:0]
    typedef enum logic [TYPE_W-1:0] {
        ex_alu         = 4'd0,
        ex_br          = 4'd1,
        ex_div         = 4'd2,
        ex_priv        = 4'd3,
        ex_mul         = 4'd4,
        ex_dcache      = 4'd5,
        ex_priv_dcache = 4'd6,
        ex_rdcnt       = 4'd7,
        ex_alu_br      = 4'd8,
        ex_ibar        = 4'd9,
        ex_priv_mmu    = 4'd10,
        ex_mmu         = 4'd11
    } exec_type_e;

endpackage

`default_nettype wire
